// ==== videoPkg.sv ====
package videoPkg;

  // screen coordinates, sized for a 160x120 frame buffer
  typedef logic [7:0] coordX_t;  // 0..159
  typedef logic [6:0] coordY_t;  // 0..119

  // one bit per channel
  typedef struct packed {
    logic red;
    logic green;
    logic blue;
  } colour_t;

  typedef struct packed {
    coordX_t x;
    coordY_t y;
  } pixelCoord_t;

  // what the frame buffer adapter consumes on each plot strobe
  typedef struct packed {
    pixelCoord_t coord;
    colour_t     colour;
  } pixelWrite_t;

  localparam colour_t blackColour = '0;  // clear colour

endpackage

// ==== motionPkg.sv ====
package motionPkg;

  // direction of travel, one flag per axis
  // 0 means towards larger coordinates (right / down)
  typedef struct packed {
    logic xLeft;
    logic yUp;
  } heading_t;

  // top-left corner of the square in screen coordinates
  typedef videoPkg::pixelCoord_t position_t;

  // reset heading is right and down
  localparam heading_t headingHome = '0;

endpackage

// ==== frameTicker.sv ====
`timescale 1ns/1ps

module frameTicker #(
  parameter int frameDivide = 833333  // 50 MHz down to about 60 Hz
) (
  input  logic clock,
  input  logic resetn,
  output logic frameTick
);

  localparam int countWidth = (frameDivide > 1) ? $clog2(frameDivide) : 1;
  localparam logic [countWidth-1:0] reloadValue = countWidth'(frameDivide - 1);

  logic [countWidth-1:0] count;  // cycles left in this frame

  always_ff @(posedge clock) begin
    if (!resetn) begin
      count     <= reloadValue;
      frameTick <= 1'b0;
    end else begin
      frameTick <= (count == '0);  // registered, so tick lands frameDivide cycles on
      if (count == '0)
        count <= reloadValue;
      else
        count <= count - 1'b1;
    end
  end

  // tick is a single-cycle strobe
  assert property (@(posedge clock) disable iff (!resetn)
    frameTick |=> !frameTick);

endmodule

// ==== rectScanner.sv ====
`timescale 1ns/1ps

module rectScanner #(
  parameter int width  = 160,
  parameter int height = 120
) (
  input  logic                 clock,
  input  logic                 resetn,
  input  logic                 start,
  output logic                 active,
  output logic                 last,
  output videoPkg::pixelCoord_t coord
);

  import videoPkg::*;

  localparam coordX_t lastX = coordX_t'(width - 1);   // right column
  localparam coordY_t lastY = coordY_t'(height - 1);  // bottom row

  // final point of the sweep
  assign last = active && (coord.x == lastX) && (coord.y == lastY);

  always_ff @(posedge clock) begin
    if (!resetn)
      active <= 1'b0;
    else if (!active)
      active <= start;  // start only counts while idle
    else if (last)
      active <= 1'b0;   // stop right after the last point
  end

  // raster walk, x fastest
  always_ff @(posedge clock) begin
    if (!active) begin
      if (start)
        coord <= '0;  // sweep begins at the origin
    end else if (!last) begin
      if (coord.x == lastX) begin
        coord.x <= '0;             // wrap into next row
        coord.y <= coord.y + 1'b1;
      end else begin
        coord.x <= coord.x + 1'b1;
      end
    end
  end

  // sweep never leaves the rectangle
  assert property (@(posedge clock) disable iff (!resetn)
    active |-> (coord.x < width) && (coord.y < height));

  // the sequencer must wait for the previous sweep to finish
  assert property (@(posedge clock) disable iff (!resetn)
    start |-> !active);

endmodule

// ==== bounceTracker.sv ====
`timescale 1ns/1ps

module bounceTracker #(
  parameter int screenWidth  = 160,
  parameter int screenHeight = 120,
  parameter int squareSide   = 4
) (
  input  logic                clock,
  input  logic                resetn,
  input  logic                moveStep,
  output motionPkg::position_t position
);

  import videoPkg::*;
  import motionPkg::*;

  // furthest top-left corner that keeps the square on screen
  localparam coordX_t maxX = coordX_t'(screenWidth - squareSide);
  localparam coordY_t maxY = coordY_t'(screenHeight - squareSide);

  heading_t heading;
  heading_t nextHeading;  // heading after edge checks

  // reverse first if already at the limit we are heading for
  always_comb begin
    nextHeading = heading;
    if (!heading.xLeft && (position.x == maxX))
      nextHeading.xLeft = 1'b1;  // right edge
    else if (heading.xLeft && (position.x == '0))
      nextHeading.xLeft = 1'b0;  // left edge
    if (!heading.yUp && (position.y == maxY))
      nextHeading.yUp = 1'b1;    // bottom edge
    else if (heading.yUp && (position.y == '0))
      nextHeading.yUp = 1'b0;    // top edge
  end

  always_ff @(posedge clock) begin
    if (!resetn) begin
      position <= '0;  // start in the top-left corner
      heading  <= headingHome;
    end else if (moveStep) begin
      heading <= nextHeading;
      // then one pixel along each axis
      if (nextHeading.xLeft)
        position.x <= position.x - 1'b1;
      else
        position.x <= position.x + 1'b1;
      if (nextHeading.yUp)
        position.y <= position.y - 1'b1;
      else
        position.y <= position.y + 1'b1;
    end
  end

  // square stays fully on screen across every step
  assert property (@(posedge clock) disable iff (!resetn)
    (position.x <= maxX) && (position.y <= maxY));

endmodule

// ==== drawSequencer.sv ====
`timescale 1ns/1ps

module drawSequencer (
  input  logic                 clock,
  input  logic                 resetn,
  input  logic                 frameTick,
  input  logic                 start,
  input  videoPkg::colour_t     colour,
  input  motionPkg::position_t  position,
  input  logic                 clearActive,
  input  logic                 clearLast,
  input  logic                 squareActive,
  input  logic                 squareLast,
  input  videoPkg::pixelCoord_t clearCoord,
  input  videoPkg::pixelCoord_t squareCoord,
  output logic                 clearStart,
  output logic                 squareStart,
  output logic                 moveStep,
  output logic                 plot,
  output videoPkg::pixelWrite_t pixel
);

  import videoPkg::*;

  typedef enum logic [1:0] {
    idle,      // waiting for a tick or start
    clearing,  // full screen black sweep
    drawing,   // square pixels
    moving     // one bounce step
  } state_t;

  state_t  state;
  state_t  nextState;
  colour_t colourReg;  // square colour for this redraw
  logic    trigger;

  assign trigger = frameTick | start;  // either one starts a redraw

  always_comb begin
    nextState = state;
    case (state)
      idle:     if (trigger) nextState = clearing;
      clearing: if (clearLast) nextState = drawing;
      drawing:  if (squareLast) nextState = moving;
      moving:   nextState = idle;  // position settles as we go idle
      default:  nextState = idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!resetn)
      state <= idle;
    else
      state <= nextState;
  end

  // colour sampled in the accepting cycle
  always_ff @(posedge clock) begin
    if ((state == idle) && trigger)
      colourReg <= colour;
  end

  // busy triggers fall through here, only idle launches the sweep
  assign clearStart  = (state == idle) && trigger;
  assign squareStart = (state == clearing) && clearLast;  // back to back, no gap
  assign moveStep    = (state == moving);

  // writes come straight off the scanners' registered coordinates
  assign plot = clearActive | squareActive;

  always_comb begin
    if (clearActive) begin
      pixel.coord  = clearCoord;
      pixel.colour = blackColour;
    end else begin
      // square pixel is corner plus raster offset
      pixel.coord.x = position.x + squareCoord.x;
      pixel.coord.y = position.y + squareCoord.y;
      pixel.colour  = colourReg;
    end
  end

  // scanners only run inside a redraw
  assert property (@(posedge clock) disable iff (!resetn)
    (state == idle) |-> !plot);

  // motion step only once the square is fully drawn
  assert property (@(posedge clock) disable iff (!resetn)
    moveStep |-> $past(squareLast));

endmodule

// ==== squareAnimator.sv ====
`timescale 1ns/1ps

module squareAnimator #(
  parameter int screenWidth  = 160,
  parameter int screenHeight = 120,
  parameter int squareSide   = 4,
  parameter int frameDivide  = 833333
) (
  input  logic                 clock,
  input  logic                 resetn,
  input  logic                 start,
  input  videoPkg::colour_t     colour,
  output logic                 plot,
  output videoPkg::pixelWrite_t pixel
);

  import videoPkg::*;
  import motionPkg::*;

  logic        frameTick;
  logic        clearStart;
  logic        clearActive;
  logic        clearLast;
  logic        squareStart;
  logic        squareActive;
  logic        squareLast;
  logic        moveStep;
  pixelCoord_t clearCoord;   // raster point on the screen
  pixelCoord_t squareCoord;  // offset inside the square
  position_t   position;

  frameTicker #(.frameDivide(frameDivide)) ticker (
    .clock(clock), .resetn(resetn), .frameTick(frameTick)
  );

  // whole screen sweep
  rectScanner #(.width(screenWidth), .height(screenHeight)) clearScan (
    .clock(clock), .resetn(resetn), .start(clearStart),
    .active(clearActive), .last(clearLast), .coord(clearCoord)
  );

  // square sized sweep
  rectScanner #(.width(squareSide), .height(squareSide)) squareScan (
    .clock(clock), .resetn(resetn), .start(squareStart),
    .active(squareActive), .last(squareLast), .coord(squareCoord)
  );

  bounceTracker #(
    .screenWidth(screenWidth), .screenHeight(screenHeight), .squareSide(squareSide)
  ) tracker (
    .clock(clock), .resetn(resetn), .moveStep(moveStep), .position(position)
  );

  drawSequencer sequencer (
    .clock(clock), .resetn(resetn), .frameTick(frameTick), .start(start),
    .colour(colour), .position(position),
    .clearActive(clearActive), .clearLast(clearLast),
    .squareActive(squareActive), .squareLast(squareLast),
    .clearCoord(clearCoord), .squareCoord(squareCoord),
    .clearStart(clearStart), .squareStart(squareStart), .moveStep(moveStep),
    .plot(plot), .pixel(pixel)
  );

endmodule

// ==== tbSquareAnimator.sv ====
`timescale 1ns/1ps

module tbSquareAnimator;

  import videoPkg::*;
  import motionPkg::*;

  localparam int screenWidth  = 16;
  localparam int screenHeight = 12;
  localparam int squareSide   = 4;
  localparam int frameDivide  = 300;

  localparam int clearWrites  = screenWidth * screenHeight;  // 192
  localparam int squareWrites = squareSide * squareSide;     // 16
  localparam int burstEnd     = clearWrites + squareWrites + 1;  // the move cycle
  localparam int maxX         = screenWidth - squareSide;
  localparam int maxY         = screenHeight - squareSide;
  localparam int frameTotal   = 30;  // enough steps to touch all four edges
  localparam int quietFrom    = 24;  // start held low from here on
  localparam int waitLimit    = frameDivide + 2 * burstEnd;

  logic        clock;
  logic        resetn;
  logic        start;
  colour_t     colour;
  logic        plot;
  pixelWrite_t pixel;

  logic [31:0] lfsrState;
  logic [31:0] startRoll;
  logic [31:0] colourRoll;
  logic        stimulusOn;
  logic        startEnable;

  // reference model state, advanced once per cycle
  int          cycleCount;
  bit          counting;
  int          burstPos;     // 0 idle, 1..208 writes, 209 move
  int          modelX;
  int          modelY;
  heading_t    modelHeading;
  colour_t     colourHistory;  // colour seen one cycle earlier
  colour_t     squareColour;
  logic [31:0] expX;
  logic [31:0] expY;
  logic [31:0] expColour;
  logic        expPlot;
  int          offset;
  bit          tickNow;
  string       testName;

  int burstsDone;
  int quietBursts;
  int busyStarts;
  int bounceLeft;
  int bounceRight;
  int bounceTop;
  int bounceBottom;

  int valueErrors;
  int timeoutErrors;
  int coverageErrors;

  squareAnimator #(
    .screenWidth(screenWidth), .screenHeight(screenHeight),
    .squareSide(squareSide), .frameDivide(frameDivide)
  ) dut (
    .clock(clock), .resetn(resetn), .start(start), .colour(colour),
    .plot(plot), .pixel(pixel)
  );

  always #20 clock = ~clock;  // 40 ns period

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ 32'h8020_0003;
    return state >> 1;
  endfunction

  // one step per bit taken
  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] result;
    result = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrStep(lfsrState);
      result    = {result[30:0], lfsrState[0]};
    end
    return result;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      valueErrors++;
      $display("Error %s: expected %0h actual %0h at %0t", name, expected, actual, $time);
    end
  endtask

  // bounce rule, reverse at the limit then move one pixel
  task automatic stepModel;
    if (!modelHeading.xLeft && modelX == maxX) begin
      modelHeading.xLeft = 1'b1;
      bounceRight++;
    end else if (modelHeading.xLeft && modelX == 0) begin
      modelHeading.xLeft = 1'b0;
      bounceLeft++;
    end
    if (!modelHeading.yUp && modelY == maxY) begin
      modelHeading.yUp = 1'b1;
      bounceBottom++;
    end else if (modelHeading.yUp && modelY == 0) begin
      modelHeading.yUp = 1'b0;
      bounceTop++;
    end
    modelX = modelHeading.xLeft ? modelX - 1 : modelX + 1;
    modelY = modelHeading.yUp ? modelY - 1 : modelY + 1;
  endtask

  task automatic waitForBurst(input int limit, output bit timedOut);
    int target;
    int waited;
    target   = burstsDone + 1;
    waited   = 0;
    timedOut = 1'b0;
    while (burstsDone < target && waited < limit) begin
      @(posedge clock);
      waited++;
    end
    if (burstsDone < target)
      timedOut = 1'b1;
  endtask

  // inputs change on the rising edge
  always @(posedge clock) begin
    if (stimulusOn) begin
      startRoll  = randomBits(6);
      colourRoll = randomBits(3);
      start  <= startEnable && (startRoll[5:0] == 6'd0);  // 1 in 64
      colour <= colourRoll[2:0];
    end
  end

  // outputs are settled at the falling edge
  always @(negedge clock) begin
    if (!resetn) begin
      checkValue("reset plot", 32'd0, plot);
      cycleCount   = 0;
      counting     = 1'b0;
      burstPos     = 0;
      modelX       = 0;  // top-left corner, heading right and down
      modelY       = 0;
      modelHeading = '0;
    end else begin
      if (counting)
        cycleCount++;
      counting = 1'b1;
      if (burstPos == 1)
        squareColour = colourHistory;  // sampled in the accepting cycle
      expPlot = (burstPos >= 1) && (burstPos <= clearWrites + squareWrites);
      if (burstPos <= clearWrites) begin
        testName  = "clearSweep";
        expX      = (burstPos - 1) % screenWidth;  // raster order, x fastest
        expY      = (burstPos - 1) / screenWidth;
        expColour = 32'd0;  // black
      end else begin
        testName  = "squareDraw";
        offset    = burstPos - clearWrites - 1;
        expX      = modelX + offset % squareSide;
        expY      = modelY + offset / squareSide;
        expColour = squareColour;
      end
      checkValue("plot strobe", expPlot, plot);
      if (expPlot && plot) begin
        checkValue({testName, " x"}, expX, pixel.coord.x);
        checkValue({testName, " y"}, expY, pixel.coord.y);
        checkValue({testName, " colour"}, expColour, pixel.colour);
      end
      colourHistory = colour;

      // tick lands every frameDivide cycles after release
      tickNow = (cycleCount != 0) && (cycleCount % frameDivide == 0);
      if (burstPos == 0) begin
        if (start || tickNow) begin
          burstPos = 1;
          if (!startEnable && !start)
            quietBursts++;  // launched by the tick alone
        end
      end else begin
        if (start)
          busyStarts++;  // must be ignored
        if (burstPos == burstEnd) begin
          stepModel();
          burstPos = 0;
          burstsDone++;
        end else begin
          burstPos++;
        end
      end
    end
  end

  initial begin
    bit timedOut;
    clock          = 1'b0;
    resetn         = 1'b0;
    start          = 1'b0;
    colour         = '0;
    stimulusOn     = 1'b0;
    startEnable    = 1'b1;
    lfsrState      = 32'h4a72_4ff0;
    burstsDone     = 0;
    quietBursts    = 0;
    busyStarts     = 0;
    bounceLeft     = 0;
    bounceRight    = 0;
    bounceTop      = 0;
    bounceBottom   = 0;
    valueErrors    = 0;
    timeoutErrors  = 0;
    coverageErrors = 0;

    repeat (10) @(posedge clock);
    resetn     <= 1'b1;
    stimulusOn <= 1'b1;

    for (int frame = 0; frame < frameTotal; frame++) begin
      if (frame == quietFrom)
        startEnable <= 1'b0;  // only frame ticks from here
      waitForBurst(waitLimit, timedOut);
      if (timedOut) begin
        timeoutErrors++;
        $display("no redraw burst finished within %0d cycles while waiting for frame %0d",
                 waitLimit, frame);
        break;
      end
    end

    if (timeoutErrors == 0) begin
      assert (bounceLeft > 0 && bounceRight > 0 && bounceTop > 0 && bounceBottom > 0)
      else begin
        coverageErrors++;
        $display("the square did not bounce off every screen edge");
      end
      assert (quietBursts > 0) else begin
        coverageErrors++;
        $display("no redraw was started by a frame tick alone");
      end
      assert (busyStarts > 0) else begin
        coverageErrors++;
        $display("no start pulse arrived while a redraw was busy");
      end
    end

    $display("errors: value %0d, timeout %0d, coverage %0d over %0d bursts",
             valueErrors, timeoutErrors, coverageErrors, burstsDone);
    if (valueErrors + timeoutErrors + coverageErrors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== build.f ====
videoPkg.sv
motionPkg.sv
frameTicker.sv
rectScanner.sv
bounceTracker.sv
drawSequencer.sv
squareAnimator.sv
tbSquareAnimator.sv
